// File: verilog.f
hw/pim_dma_pkg.sv
hw/pim_cmd_reg.sv
hw/pim_dma_ctrl.sv
hw/pim_addr_gen.sv
hw/pim_port_mux.sv
hw/pim_dma_top.sv
tb/pim_bus_model.sv
tb/tb_pim_dma.sv

// File: Bender.yml
package:
  name: pim_dma

sources:
  - files:
      - hw/pim_dma_pkg.sv
      - hw/pim_cmd_reg.sv
      - hw/pim_dma_ctrl.sv
      - hw/pim_addr_gen.sv
      - hw/pim_port_mux.sv
      - hw/pim_dma_top.sv
  - target: test
    files:
      - tb/pim_bus_model.sv
      - tb/tb_pim_dma.sv

// File: tb/tb_pim_dma.sv
`timescale 1ns/100ps

module tb_pim_dma;

    localparam pim_dma_pkg::word_t BASE_ADDR   = pim_dma_pkg::DEF_PIM_BASE_ADDR;
    localparam pim_dma_pkg::word_t STATUS_ADDR = pim_dma_pkg::DEF_PIM_STATUS_ADDR;
    localparam pim_dma_pkg::word_t MODE_ADDR   = pim_dma_pkg::DEF_PIM_MODE_ADDR;
    // all tests together take a few hundred cycles including random grant
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int IDLE_WAIT      = 200;

    logic                   clk_i;
    logic                   rst_ni;
    logic                   dma_en_i;
    logic [2:0]             funct3_i;
    pim_dma_pkg::word_t     rs1_i;
    pim_dma_pkg::word_t     rs2_i;
    logic                   bus_req_o;
    logic                   bus_gnt_i;
    logic                   dma_busy_o;
    pim_dma_pkg::port_req_t sram_req_o;
    pim_dma_pkg::word_t     sram_rdata_i;
    pim_dma_pkg::port_req_t pim_req_o;
    pim_dma_pkg::word_t     pim_rdata_i;
    pim_dma_pkg::word_t     pim_status;

    integer             seed;
    logic               gnt_random;
    logic [31:0]        gnt_draw;
    pim_dma_pkg::word_t exp_word [0:15];
    int                 cycle_cnt;
    int                 busy_cycles;
    int                 req_cycles;
    int                 stray_strobes;
    int                 bad_sizes;
    int                 num_checks;
    int                 value_errs;
    int                 other_errs;

    pim_dma_top #(
        .PIM_BASE_ADDR   (BASE_ADDR),
        .PIM_STATUS_ADDR (STATUS_ADDR),
        .PIM_MODE_ADDR   (MODE_ADDR)
    ) DUT (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .dma_en_i     (dma_en_i),
        .funct3_i     (funct3_i),
        .rs1_i        (rs1_i),
        .rs2_i        (rs2_i),
        .bus_req_o    (bus_req_o),
        .bus_gnt_i    (bus_gnt_i),
        .dma_busy_o   (dma_busy_o),
        .sram_req_o   (sram_req_o),
        .sram_rdata_i (sram_rdata_i),
        .pim_req_o    (pim_req_o),
        .pim_rdata_i  (pim_rdata_i)
    );

    pim_bus_model #(
        .BASE_ADDR   (BASE_ADDR),
        .STATUS_ADDR (STATUS_ADDR)
    ) u_bus_model (
        .clk_i        (clk_i),
        .gnt_i        (bus_gnt_i),
        .status_i     (pim_status),
        .sram_req_i   (sram_req_o),
        .pim_req_i    (pim_req_o),
        .sram_rdata_o (sram_rdata_i),
        .pim_rdata_o  (pim_rdata_i)
    );

    always #20 clk_i = ~clk_i;

    // grant held high unless a test asks for a random pattern
    always @(posedge clk_i) begin
        if (gnt_random) begin
            gnt_draw = $random(seed);
            bus_gnt_i <= gnt_draw[0];
        end else begin
            bus_gnt_i <= 1'b1;
        end
    end

    // busy and request length and transfer strobes seen without grant
    always @(negedge clk_i) begin
        if (dma_busy_o) begin
            busy_cycles++;
        end
        if (bus_req_o) begin
            req_cycles++;
        end
        if (!bus_gnt_i && (sram_req_o.read || sram_req_o.write || sram_req_o.size != '0
                || (pim_req_o.write && pim_req_o.addr != MODE_ADDR)
                || (pim_req_o.read && pim_req_o.addr != STATUS_ADDR))) begin
            stray_strobes++;
        end
        // every strobe moves a full word
        if (((sram_req_o.read || sram_req_o.write) && sram_req_o.size != '1)
                || ((pim_req_o.read || pim_req_o.write) && pim_req_o.size != '1)) begin
            bad_sizes++;
        end
    end

    task automatic check_val(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
        num_checks++;
        assert (got === exp) else begin
            value_errs++;
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic report_fail(input string msg);
        other_errs++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    task automatic print_counts();
        $display("checks %0d, value errors %0d, other errors %0d",
                 num_checks, value_errs, other_errs);
    endtask

    task automatic set_status(input pim_dma_pkg::word_t value);
        @(posedge clk_i);
        pim_status <= value;
    endtask

    // one-cycle command pulse
    task automatic issue_cmd(input logic [2:0] code, input pim_dma_pkg::word_t rs1,
                             input pim_dma_pkg::word_t rs2);
        @(posedge clk_i);
        dma_en_i <= 1'b1;
        funct3_i <= code;
        rs1_i    <= rs1;
        rs2_i    <= rs2;
        @(posedge clk_i);
        dma_en_i <= 1'b0;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk_i);
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk_i);
        while (dma_busy_o && n < IDLE_WAIT) begin
            @(negedge clk_i);
            n++;
        end
        assert (!dma_busy_o) else report_fail("engine never returned to idle");
    endtask

    task automatic check_idle_outputs();
        check_val("dma_busy_o", dma_busy_o, 1'b0);
        check_val("bus_req_o", bus_req_o, 1'b0);
        check_val("sram_req_o", sram_req_o, '0);
        check_val("pim_req_o", pim_req_o, '0);
    endtask

    task automatic check_mode_write(input pim_dma_pkg::op_t op);
        check_val("pim_req_o.addr", u_bus_model.log_addr[0], MODE_ADDR);
        check_val("pim_req_o.wdata", u_bus_model.log_data[0], pim_dma_pkg::word_t'(op));
    endtask

    task automatic fill_sram(input pim_dma_pkg::word_t rs2, input int n);
        pim_dma_pkg::word_t addr;
        for (int k = 0; k < n; k++) begin
            addr = rs2 + 4 * k;
            exp_word[k] = $random(seed);
            u_bus_model.sram_mem[addr[9:2]] = exp_word[k];
        end
    endtask

    // mode write first, then beat k at row OR (k << 12) with SRAM word k
    task automatic check_stream(input pim_dma_pkg::op_t op, input pim_dma_pkg::word_t rs1,
                                input int beats);
        pim_dma_pkg::word_t exp_addr;
        check_val("log_cnt", u_bus_model.log_cnt, beats + 1);
        check_mode_write(op);
        for (int k = 0; k < beats; k++) begin
            exp_addr = (BASE_ADDR + rs1) | (pim_dma_pkg::word_t'(k) << pim_dma_pkg::BEAT_SHIFT);
            check_val("pim_req_o.addr", u_bus_model.log_addr[k + 1], exp_addr);
            check_val("pim_req_o.wdata", u_bus_model.log_data[k + 1], exp_word[k]);
        end
    endtask

    task automatic test_reset();
        @(negedge clk_i);
        check_idle_outputs();
    endtask

    task automatic test_write_op(input pim_dma_pkg::op_t op, input pim_dma_pkg::word_t rs1,
                                 input pim_dma_pkg::word_t rs2);
        gnt_random = 1'b0;
        set_status(32'h1);
        u_bus_model.clear_log();
        busy_cycles = 0;
        req_cycles  = 0;
        issue_cmd(op, rs1, rs2);
        wait_idle();
        check_val("log_cnt", u_bus_model.log_cnt, 2);
        check_mode_write(op);
        check_val("pim_req_o.addr", u_bus_model.log_addr[1], BASE_ADDR + rs1);
        check_val("pim_req_o.wdata", u_bus_model.log_data[1], rs2);
        check_val("dma_busy_o cycles", busy_cycles, 3);
        check_val("bus_req_o cycles", req_cycles, 3);
    endtask

    task automatic test_parallel();
        gnt_random = 1'b0;
        set_status(32'h1);
        fill_sram(32'h0000_0100, 16);
        u_bus_model.clear_log();
        busy_cycles = 0;
        req_cycles  = 0;
        issue_cmd(pim_dma_pkg::OP_PARALLEL, 32'h0000_0020, 32'h0000_0100);
        wait_cycles(3);
        // second command mid-transfer must be dropped
        issue_cmd(pim_dma_pkg::OP_ERASE, 32'h0000_0040, 32'hdead_beef);
        wait_idle();
        wait_cycles(3);
        check_val("dma_busy_o", dma_busy_o, 1'b0);
        check_val("dma_busy_o cycles", busy_cycles, 18);
        check_val("bus_req_o cycles", req_cycles, 18);
        check_stream(pim_dma_pkg::OP_PARALLEL, 32'h0000_0020, 16);
    endtask

    task automatic test_rbr();
        gnt_random = 1'b1;
        set_status(32'h0);
        fill_sram(32'h0000_0200, 2);
        u_bus_model.clear_log();
        stray_strobes = 0;
        issue_cmd(pim_dma_pkg::OP_RBR, 32'h0000_0a00, 32'h0000_0200);
        wait_cycles(12);
        // ready low keeps the engine polling
        check_val("dma_busy_o", dma_busy_o, 1'b1);
        check_val("log_cnt", u_bus_model.log_cnt, 0);
        set_status(32'h1);
        wait_idle();
        gnt_random = 1'b0;
        check_stream(pim_dma_pkg::OP_RBR, 32'h0000_0a00, 2);
        check_val("ungranted strobes", stray_strobes, 0);
    endtask

    task automatic test_read();
        pim_dma_pkg::word_t pim_addr;
        pim_dma_pkg::word_t sram_addr;
        pim_dma_pkg::word_t exp;
        pim_addr  = BASE_ADDR + 32'h0000_0018;
        sram_addr = 32'h0000_0300;
        exp       = $random(seed);
        u_bus_model.pim_mem[pim_addr[7:2]]   = exp;
        u_bus_model.sram_mem[sram_addr[9:2]] = ~exp;
        gnt_random = 1'b0;
        set_status(32'h1);
        u_bus_model.clear_log();
        issue_cmd(pim_dma_pkg::OP_READ, 32'h0000_0018, sram_addr);
        wait_cycles(10);
        check_val("dma_busy_o", dma_busy_o, 1'b1);
        set_status(32'h3);
        wait_idle();
        check_val("sram_mem[rs2]", u_bus_model.sram_mem[sram_addr[9:2]], exp);
        check_val("log_cnt", u_bus_model.log_cnt, 1);
        check_mode_write(pim_dma_pkg::OP_READ);
    endtask

    task automatic test_reject(input logic [2:0] code);
        gnt_random = 1'b0;
        set_status(32'h3);
        u_bus_model.clear_log();
        issue_cmd(code, 32'h0000_0010, 32'h0000_0100);
        repeat (4) begin
            @(negedge clk_i);
            check_idle_outputs();
        end
        check_val("log_cnt", u_bus_model.log_cnt, 0);
    endtask

    initial begin
        seed          = 32'h297a_78f1;
        clk_i         = 1'b0;
        rst_ni        = 1'b0;
        dma_en_i      = 1'b0;
        funct3_i      = 3'd0;
        rs1_i         = '0;
        rs2_i         = '0;
        bus_gnt_i     = 1'b0;
        pim_status    = '0;
        gnt_random    = 1'b0;
        busy_cycles   = 0;
        req_cycles    = 0;
        stray_strobes = 0;
        bad_sizes     = 0;
        num_checks    = 0;
        value_errs    = 0;
        other_errs    = 0;
        repeat (8) @(posedge clk_i);
        rst_ni <= 1'b1;
        test_reset();
        test_write_op(pim_dma_pkg::OP_ERASE, 32'h0000_0004, 32'h1234_5678);
        test_write_op(pim_dma_pkg::OP_PROGRAM, 32'h0000_0c08, 32'h0bad_cafe);
        test_parallel();
        test_rbr();
        test_read();
        test_reject(3'd0);
        test_reject(3'd6);
        test_reject(3'd7);
        check_val("strobe size errors", bad_sizes, 0);
        print_counts();
        if (value_errs == 0 && other_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // run limit
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        other_errs++;
        $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        print_counts();
        $display("sim failed");
        $finish;
    end

endmodule

// File: tb/pim_bus_model.sv
`timescale 1ns/100ps

module pim_bus_model #(
    parameter pim_dma_pkg::word_t BASE_ADDR   = pim_dma_pkg::DEF_PIM_BASE_ADDR,
    parameter pim_dma_pkg::word_t STATUS_ADDR = pim_dma_pkg::DEF_PIM_STATUS_ADDR
) (
    input  logic                   clk_i,
    input  logic                   gnt_i,
    input  pim_dma_pkg::word_t     status_i,
    input  pim_dma_pkg::port_req_t sram_req_i,
    input  pim_dma_pkg::port_req_t pim_req_i,
    output pim_dma_pkg::word_t     sram_rdata_o,
    output pim_dma_pkg::word_t     pim_rdata_o
);

    localparam int LOG_DEPTH = 64;

    pim_dma_pkg::word_t sram_mem [0:255];
    pim_dma_pkg::word_t pim_mem [0:63];

    // granted PIM writes in arrival order
    pim_dma_pkg::word_t log_addr [0:LOG_DEPTH-1];
    pim_dma_pkg::word_t log_data [0:LOG_DEPTH-1];
    int                 log_cnt = 0;

    // both ports answer in the cycle of the read strobe
    always_comb begin
        sram_rdata_o = '0;
        if (sram_req_i.read) begin
            sram_rdata_o = sram_mem[sram_req_i.addr[9:2]];
        end
    end

    // macro array sits in a 256-byte window at the base address
    always_comb begin
        pim_rdata_o = '0;
        if (pim_req_i.read && pim_req_i.addr == STATUS_ADDR) begin
            pim_rdata_o = status_i;
        end else if (pim_req_i.read && pim_req_i.addr[31:8] == BASE_ADDR[31:8]) begin
            pim_rdata_o = pim_mem[pim_req_i.addr[7:2]];
        end
    end

    // writes only land when the bus is granted
    always @(posedge clk_i) begin
        if (gnt_i && sram_req_i.write) begin
            sram_mem[sram_req_i.addr[9:2]] <= sram_req_i.wdata;
        end
        if (gnt_i && pim_req_i.write && log_cnt < LOG_DEPTH) begin
            log_addr[log_cnt] <= pim_req_i.addr;
            log_data[log_cnt] <= pim_req_i.wdata;
            log_cnt           <= log_cnt + 1;
        end
    end

    task automatic clear_log();
        log_cnt = 0;
    endtask

endmodule

// File: hw/pim_dma_top.sv
`timescale 1ns/100ps

module pim_dma_top #(
    parameter pim_dma_pkg::word_t PIM_BASE_ADDR   = pim_dma_pkg::DEF_PIM_BASE_ADDR,
    parameter pim_dma_pkg::word_t PIM_STATUS_ADDR = pim_dma_pkg::DEF_PIM_STATUS_ADDR,
    parameter pim_dma_pkg::word_t PIM_MODE_ADDR   = pim_dma_pkg::DEF_PIM_MODE_ADDR
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    // command from the core
    input  logic                   dma_en_i,
    input  logic [2:0]             funct3_i,
    input  pim_dma_pkg::word_t     rs1_i,
    input  pim_dma_pkg::word_t     rs2_i,
    // bus arbitration
    output logic                   bus_req_o,
    input  logic                   bus_gnt_i,
    output logic                   dma_busy_o,
    // SRAM port
    output pim_dma_pkg::port_req_t sram_req_o,
    input  pim_dma_pkg::word_t     sram_rdata_i,
    // PIM port
    output pim_dma_pkg::port_req_t pim_req_o,
    input  pim_dma_pkg::word_t     pim_rdata_i
);

    logic                    accept;
    pim_dma_pkg::cmd_t       cmd;
    pim_dma_pkg::beat_cnt_t  beats;
    pim_dma_pkg::dma_state_e state;
    logic                    load_cnt;
    logic                    beat_en;
    logic                    last_beat;
    pim_dma_pkg::word_t      sram_addr;
    pim_dma_pkg::word_t      pim_addr;

    pim_cmd_reg u_cmd_reg (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .dma_en_i (dma_en_i),
        .busy_i   (dma_busy_o),
        .funct3_i (funct3_i),
        .rs1_i    (rs1_i),
        .rs2_i    (rs2_i),
        .accept_o (accept),
        .cmd_o    (cmd),
        .beats_o  (beats)
    );

    // status word comes back on the PIM read data
    pim_dma_ctrl u_ctrl (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .accept_i     (accept),
        .bus_gnt_i    (bus_gnt_i),
        .last_beat_i  (last_beat),
        .cmd_i        (cmd),
        .pim_status_i (pim_rdata_i),
        .state_o      (state),
        .load_cnt_o   (load_cnt),
        .beat_en_o    (beat_en),
        .bus_req_o    (bus_req_o),
        .busy_o       (dma_busy_o)
    );

    pim_addr_gen #(
        .PIM_BASE_ADDR (PIM_BASE_ADDR)
    ) u_addr_gen (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .load_cnt_i  (load_cnt),
        .beat_en_i   (beat_en),
        .cmd_i       (cmd),
        .beats_i     (beats),
        .last_beat_o (last_beat),
        .sram_addr_o (sram_addr),
        .pim_addr_o  (pim_addr)
    );

    pim_port_mux #(
        .PIM_STATUS_ADDR (PIM_STATUS_ADDR),
        .PIM_MODE_ADDR   (PIM_MODE_ADDR)
    ) u_port_mux (
        .state_i      (state),
        .beat_en_i    (beat_en),
        .cmd_i        (cmd),
        .sram_addr_i  (sram_addr),
        .pim_addr_i   (pim_addr),
        .sram_rdata_i (sram_rdata_i),
        .pim_rdata_i  (pim_rdata_i),
        .sram_req_o   (sram_req_o),
        .pim_req_o    (pim_req_o)
    );

endmodule

// File: hw/pim_port_mux.sv
`timescale 1ns/100ps

module pim_port_mux #(
    parameter pim_dma_pkg::word_t PIM_STATUS_ADDR = pim_dma_pkg::DEF_PIM_STATUS_ADDR,
    parameter pim_dma_pkg::word_t PIM_MODE_ADDR   = pim_dma_pkg::DEF_PIM_MODE_ADDR
) (
    input  pim_dma_pkg::dma_state_e state_i,
    input  logic                    beat_en_i,
    input  pim_dma_pkg::cmd_t       cmd_i,
    input  pim_dma_pkg::word_t      sram_addr_i,
    input  pim_dma_pkg::word_t      pim_addr_i,
    input  pim_dma_pkg::word_t      sram_rdata_i,
    input  pim_dma_pkg::word_t      pim_rdata_i,
    output pim_dma_pkg::port_req_t  sram_req_o,
    output pim_dma_pkg::port_req_t  pim_req_o
);

    always_comb begin
        sram_req_o = '0;
        pim_req_o  = '0;
        case (state_i)
            pim_dma_pkg::ST_POLL: begin
                // status read every poll cycle
                pim_req_o.addr = PIM_STATUS_ADDR;
                pim_req_o.read = 1'b1;
                pim_req_o.size = '1;
            end
            pim_dma_pkg::ST_MODE: begin
                // op code goes to the mode register
                pim_req_o.addr  = PIM_MODE_ADDR;
                pim_req_o.write = 1'b1;
                pim_req_o.size  = '1;
                pim_req_o.wdata = pim_dma_pkg::word_t'(cmd_i.op);
            end
            pim_dma_pkg::ST_XFER: begin
                if (beat_en_i) begin
                    case (cmd_i.op)
                        pim_dma_pkg::OP_ERASE, pim_dma_pkg::OP_PROGRAM: begin
                            // timing word straight to the PIM
                            pim_req_o.addr  = pim_addr_i;
                            pim_req_o.write = 1'b1;
                            pim_req_o.size  = '1;
                            pim_req_o.wdata = cmd_i.mem_word;
                        end
                        pim_dma_pkg::OP_PARALLEL, pim_dma_pkg::OP_RBR: begin
                            sram_req_o.addr = sram_addr_i;
                            sram_req_o.read = 1'b1;
                            sram_req_o.size = '1;
                            // SRAM word passes through in the same cycle
                            pim_req_o.addr  = pim_addr_i;
                            pim_req_o.write = 1'b1;
                            pim_req_o.size  = '1;
                            pim_req_o.wdata = sram_rdata_i;
                        end
                        pim_dma_pkg::OP_READ: begin
                            pim_req_o.addr   = pim_addr_i;
                            pim_req_o.read   = 1'b1;
                            pim_req_o.size   = '1;
                            sram_req_o.addr  = sram_addr_i;
                            sram_req_o.write = 1'b1;
                            sram_req_o.size  = '1;
                            sram_req_o.wdata = pim_rdata_i;
                        end
                        default: begin
                            // no bus activity for other codes
                            sram_req_o = '0;
                            pim_req_o  = '0;
                        end
                    endcase
                end
            end
            default: begin
                sram_req_o = '0;
                pim_req_o  = '0;
            end
        endcase
    end

endmodule

// File: hw/pim_addr_gen.sv
`timescale 1ns/100ps

module pim_addr_gen #(
    parameter pim_dma_pkg::word_t PIM_BASE_ADDR = pim_dma_pkg::DEF_PIM_BASE_ADDR
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   load_cnt_i,
    input  logic                   beat_en_i,
    input  pim_dma_pkg::cmd_t      cmd_i,
    input  pim_dma_pkg::beat_cnt_t beats_i,
    output logic                   last_beat_o,
    output pim_dma_pkg::word_t     sram_addr_o,
    output pim_dma_pkg::word_t     pim_addr_o
);

    pim_dma_pkg::beat_cnt_t cnt_q;
    pim_dma_pkg::beat_cnt_t beat_idx;
    pim_dma_pkg::word_t     sram_ptr_q;
    pim_dma_pkg::word_t     pim_row;

    // remaining beats
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_q <= '0;
        end else if (load_cnt_i) begin
            cnt_q <= beats_i;
        end else if (beat_en_i) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // SRAM word pointer, starts at rs2
    always_ff @(posedge clk_i) begin
        if (load_cnt_i) begin
            sram_ptr_q <= cmd_i.mem_word;
        end else if (beat_en_i) begin
            sram_ptr_q <= sram_ptr_q + pim_dma_pkg::WORD_BYTES;
        end
    end

    assign last_beat_o = (cnt_q == pim_dma_pkg::beat_cnt_t'(1));
    assign sram_addr_o = sram_ptr_q;

    // beats already done, counts up from 0
    assign beat_idx = beats_i - cnt_q;
    assign pim_row  = PIM_BASE_ADDR + cmd_i.rc_addr;

    always_comb begin
        case (cmd_i.op)
            pim_dma_pkg::OP_PARALLEL, pim_dma_pkg::OP_RBR: begin
                pim_addr_o = pim_row
                           | (pim_dma_pkg::word_t'(beat_idx) << pim_dma_pkg::BEAT_SHIFT);
            end
            default: begin
                pim_addr_o = pim_row;
            end
        endcase
    end

    // controller never asks for a beat past the end of the count
    a_no_beat_at_zero: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        beat_en_i |-> cnt_q != '0
    );

endmodule

// File: hw/pim_dma_ctrl.sv
`timescale 1ns/100ps

module pim_dma_ctrl (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    accept_i,
    input  logic                    bus_gnt_i,
    input  logic                    last_beat_i,
    input  pim_dma_pkg::cmd_t       cmd_i,
    input  pim_dma_pkg::word_t      pim_status_i,
    output pim_dma_pkg::dma_state_e state_o,
    output logic                    load_cnt_o,
    output logic                    beat_en_o,
    output logic                    bus_req_o,
    output logic                    busy_o
);

    pim_dma_pkg::dma_state_e state_q;
    pim_dma_pkg::dma_state_e state_d;
    logic                    status_ok;

    // writes need ready only and READ also waits for data valid
    always_comb begin
        status_ok = pim_status_i[pim_dma_pkg::STAT_READY_BIT];
        if (cmd_i.op == pim_dma_pkg::OP_READ) begin
            status_ok = status_ok && pim_status_i[pim_dma_pkg::STAT_DATA_VALID_BIT];
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            pim_dma_pkg::ST_IDLE: begin
                if (accept_i) begin
                    state_d = pim_dma_pkg::ST_POLL;
                end
            end
            pim_dma_pkg::ST_POLL: begin
                if (bus_gnt_i && status_ok) begin
                    state_d = pim_dma_pkg::ST_MODE;
                end
            end
            pim_dma_pkg::ST_MODE: begin
                if (bus_gnt_i) begin
                    state_d = pim_dma_pkg::ST_XFER;
                end
            end
            pim_dma_pkg::ST_XFER: begin
                if (beat_en_o && last_beat_i) begin
                    state_d = pim_dma_pkg::ST_IDLE;
                end
            end
            default: begin
                state_d = pim_dma_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= pim_dma_pkg::ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // mode write and beats only count in granted cycles
    assign load_cnt_o = (state_q == pim_dma_pkg::ST_MODE) && bus_gnt_i;
    assign beat_en_o  = (state_q == pim_dma_pkg::ST_XFER) && bus_gnt_i;

    assign busy_o    = (state_q != pim_dma_pkg::ST_IDLE);
    assign bus_req_o = busy_o;
    assign state_o   = state_q;

    // command register only accepts while the FSM sits in idle
    a_accept_idle: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        accept_i |-> state_q == pim_dma_pkg::ST_IDLE
    );

endmodule

// File: hw/pim_cmd_reg.sv
`timescale 1ns/100ps

module pim_cmd_reg (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   dma_en_i,
    input  logic                   busy_i,
    input  logic [2:0]             funct3_i,
    input  pim_dma_pkg::word_t     rs1_i,
    input  pim_dma_pkg::word_t     rs2_i,
    output logic                   accept_o,
    output pim_dma_pkg::cmd_t      cmd_o,
    output pim_dma_pkg::beat_cnt_t beats_o
);

    logic                   op_kept;
    pim_dma_pkg::beat_cnt_t beats_d;

    // decode funct3 into beat count and kept flag
    always_comb begin
        op_kept = 1'b1;
        beats_d = '0;
        case (funct3_i)
            pim_dma_pkg::OP_ERASE: begin
                beats_d = pim_dma_pkg::BEATS_ERASE;
            end
            pim_dma_pkg::OP_PROGRAM: begin
                beats_d = pim_dma_pkg::BEATS_PROGRAM;
            end
            pim_dma_pkg::OP_READ: begin
                beats_d = pim_dma_pkg::BEATS_READ;
            end
            pim_dma_pkg::OP_PARALLEL: begin
                beats_d = pim_dma_pkg::BEATS_PARALLEL;
            end
            pim_dma_pkg::OP_RBR: begin
                beats_d = pim_dma_pkg::BEATS_RBR;
            end
            default: begin
                // LOAD and undefined codes fall through here
                op_kept = 1'b0;
            end
        endcase
    end

    assign accept_o = dma_en_i && !busy_i && op_kept;

    // command fields held for the whole operation
    always_ff @(posedge clk_i) begin
        if (accept_o) begin
            cmd_o.op       <= pim_dma_pkg::op_t'(funct3_i);
            cmd_o.rc_addr  <= rs1_i;
            cmd_o.mem_word <= rs2_i;
            beats_o        <= beats_d;
        end
    end

    // controller goes busy right after acceptance
    a_accept_busy: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        accept_o |=> busy_i
    );

endmodule

// File: hw/pim_dma_pkg.sv
package pim_dma_pkg;

    // data and address word on both ports
    typedef logic [31:0] word_t;

    // remaining beats, 0 to 16
    typedef logic [4:0] beat_cnt_t;

    // byte enables of one bus port
    typedef logic [3:0] byte_en_t;

    // funct3 codes of the kept operations
    typedef enum logic [2:0] {
        OP_ERASE    = 3'd1,
        OP_PROGRAM  = 3'd2,
        OP_READ     = 3'd3,
        OP_PARALLEL = 3'd4,
        OP_RBR      = 3'd5
    } op_t;

    // transfer beats per operation
    localparam beat_cnt_t BEATS_ERASE    = 5'd1;
    localparam beat_cnt_t BEATS_PROGRAM  = 5'd1;
    localparam beat_cnt_t BEATS_READ     = 5'd1;
    localparam beat_cnt_t BEATS_PARALLEL = 5'd16;
    localparam beat_cnt_t BEATS_RBR      = 5'd2;

    // beat index lands at this PIM address bit
    localparam int unsigned BEAT_SHIFT = 12;
    localparam word_t WORD_BYTES = 32'd4;

    localparam word_t DEF_PIM_BASE_ADDR   = 32'h4000_0000;
    localparam word_t DEF_PIM_STATUS_ADDR = 32'h4100_0000;
    localparam word_t DEF_PIM_MODE_ADDR   = 32'h4200_0000;

    // PIM status word bits
    localparam int unsigned STAT_READY_BIT      = 0;
    localparam int unsigned STAT_DATA_VALID_BIT = 1;

    typedef enum logic [1:0] {ST_IDLE, ST_POLL, ST_MODE, ST_XFER} dma_state_e;

    typedef struct packed {
        op_t   op;
        word_t rc_addr;
        word_t mem_word;
    } cmd_t;

    typedef struct packed {
        word_t    addr;
        logic     write;
        logic     read;
        byte_en_t size;
        word_t    wdata;
    } port_req_t;

endpackage
